// ==== Bender.yml ====
package:
  name: lcm_display

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lcm_pkg.sv
      - hdl/lcm_clk_gen.sv
      - hdl/lcm_timing_ctrl.sv
      - hdl/lcm_frame_buf.sv
      - hdl/lcm_host_if.sv
      - hdl/lcm_display_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/lcm_display_chk.sv
      - testbench/lcm_display_tb.sv

// ==== hdl/lcm_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lcm_settings.svh"

module lcm_clk_gen (
	input  wire  clk,
	input  wire  rst_n,
	output logic lcm_clk,
	output logic lcm_clk_event
);

	localparam int CNT_W = ($clog2(`LCM_CLK_DIV) > 0) ? $clog2(`LCM_CLK_DIV) : 1;

	logic [CNT_W-1:0] div_cnt;
	logic             div_done;

	assign div_done = (div_cnt == CNT_W'(`LCM_CLK_DIV - 1));

	// free running, so panel clock phase does not follow refresh requests
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt       <= '0;
			lcm_clk       <= 1'b0;
			lcm_clk_event <= 1'b0;
		end else begin
			lcm_clk_event <= 1'b0;
			if (div_done) begin
				div_cnt       <= '0;
				lcm_clk       <= ~lcm_clk;
				lcm_clk_event <= 1'b1;  // same edge as the toggle
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/lcm_display_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcm_display_top (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                req,
	input  lcm_pkg::lcm_cmd_u  cmd,
	output logic               ack,
	output logic               xscl,
	output logic               lcm_lp,
	output logic               lcm_din,
	output logic               busy,
	output lcm_pkg::lcm_byte_t lcm_data
);

	import lcm_pkg::*;

	logic       wr_en;
	lcm_index_t wr_addr;
	lcm_byte_t  wr_data;
	logic       request_update;
	lcm_index_t rd_index;
	logic       lcm_clk;
	logic       lcm_clk_event;

	lcm_host_if host_if_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.req            (req),
		.cmd            (cmd),
		.busy           (busy),
		.ack            (ack),
		.wr_en          (wr_en),
		.request_update (request_update),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data)
	);

	lcm_frame_buf frame_buf_i (
		.clk      (clk),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_index (rd_index),
		.rd_data  (lcm_data)  // straight to the panel bus
	);

	lcm_clk_gen clk_gen_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.lcm_clk       (lcm_clk),
		.lcm_clk_event (lcm_clk_event)
	);

	lcm_timing_ctrl timing_ctrl_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.request_update (request_update),
		.lcm_clk        (lcm_clk),
		.lcm_clk_event  (lcm_clk_event),
		.rd_index       (rd_index),
		.xscl           (xscl),
		.lcm_lp         (lcm_lp),
		.lcm_din        (lcm_din),
		.busy           (busy)
	);

endmodule

`default_nettype wire

// ==== hdl/lcm_frame_buf.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcm_frame_buf (
	input  wire                 clk,
	input  wire                 wr_en,
	input  lcm_pkg::lcm_index_t wr_addr,
	input  lcm_pkg::lcm_byte_t  wr_data,
	input  lcm_pkg::lcm_index_t rd_index,
	output lcm_pkg::lcm_byte_t  rd_data
);

	import lcm_pkg::*;

	lcm_byte_t mem [LCM_DATA_BYTES];  // one frame, row major

	// host write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// panel read port, one cycle latency
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_index];
	end

endmodule

`default_nettype wire

// ==== hdl/lcm_host_if.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcm_host_if (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire                 req,
	input  lcm_pkg::lcm_cmd_u   cmd,
	input  wire                 busy,
	output logic                ack,
	output logic                wr_en,
	output logic                request_update,
	output lcm_pkg::lcm_index_t wr_addr,
	output lcm_pkg::lcm_byte_t  wr_data
);

	import lcm_pkg::*;

	localparam logic [1:0] HS_IDLE = 2'd0;
	localparam logic [1:0] HS_WAIT = 2'd1;  // refresh held off by busy
	localparam logic [1:0] HS_ACK  = 2'd2;

	logic [1:0] hs_state;

	// handshake and strobes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hs_state       <= HS_IDLE;
			ack            <= 1'b0;
			wr_en          <= 1'b0;
			request_update <= 1'b0;
		end else begin
			wr_en          <= 1'b0;
			request_update <= 1'b0;
			case (hs_state)
				HS_IDLE: begin
					if (req) begin
						case (cmd.pix.op)
							op_write_pixel: begin
								wr_en    <= 1'b1;
								ack      <= 1'b1;
								hs_state <= HS_ACK;
							end
							op_refresh: hs_state <= HS_WAIT;
							default: begin  // nop, acked with no effect
								ack      <= 1'b1;
								hs_state <= HS_ACK;
							end
						endcase
					end
				end
				HS_WAIT: begin
					if (!busy) begin
						// only full frame refresh exists, a cleared flag acts as nop
						request_update <= cmd.ctl.full_frame;
						ack            <= 1'b1;
						hs_state       <= HS_ACK;
					end
				end
				HS_ACK: begin
					if (!req) begin
						ack      <= 1'b0;
						hs_state <= HS_IDLE;
					end
				end
				default: hs_state <= HS_IDLE;
			endcase
		end
	end

	// write payload, qualified by wr_en
	always_ff @(posedge clk) begin
		if (hs_state == HS_IDLE && req) begin
			wr_addr <= cmd.pix.addr;
			wr_data <= cmd.pix.data;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/lcm_pkg.sv ====
`default_nettype none

`include "lcm_settings.svh"

package lcm_pkg;

	localparam int LCM_WIDTH_BYTES = `LCM_WIDTH_BITS / `LCM_BYTE_WIDTH;   // bytes per line
	localparam int LCM_DATA_BYTES  = LCM_WIDTH_BYTES * `LCM_HEIGHT_LINES; // bytes per frame
	localparam int LCM_INDEX_W     = $clog2(LCM_DATA_BYTES);

	typedef logic [LCM_INDEX_W-1:0]     lcm_index_t;
	typedef logic [`LCM_BYTE_WIDTH-1:0] lcm_byte_t;

	typedef enum logic [1:0] {
		op_nop         = 2'd0,
		op_write_pixel = 2'd1,
		op_refresh     = 2'd2
	} lcm_op_e;

	// host command word, opcode on top in both views
	typedef union packed {
		struct packed {
			lcm_op_e    op;
			lcm_index_t addr;  // frame buffer byte address
			lcm_byte_t  data;  // eight pixels
		} pix;
		struct packed {
			lcm_op_e    op;
			logic       full_frame;
			logic [LCM_INDEX_W+`LCM_BYTE_WIDTH-2:0] reserved;
		} ctl;
	} lcm_cmd_u;

endpackage

`default_nettype wire

// ==== hdl/lcm_settings.svh ====
`ifndef LCM_SETTINGS_SVH
`define LCM_SETTINGS_SVH

// panel geometry
`define LCM_WIDTH_BITS   64  // pixels per line
`define LCM_HEIGHT_LINES 8   // lines per frame
`define LCM_BYTE_WIDTH   8   // pixels packed per data byte

// panel clock, in clk cycles per half period
`define LCM_CLK_DIV      4

// lp high time in panel clock periods
`define LCM_LP_DELAY     10

`endif

// ==== hdl/lcm_timing_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lcm_settings.svh"

module lcm_timing_ctrl (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                request_update,
	input  wire                lcm_clk,
	input  wire                lcm_clk_event,
	output lcm_pkg::lcm_index_t rd_index,
	output logic               xscl,
	output logic               lcm_lp,
	output logic               lcm_din,
	output logic               busy
);

	import lcm_pkg::*;

	localparam logic [2:0] ST_IDLE     = 3'd0;
	localparam logic [2:0] ST_START    = 3'd1;
	localparam logic [2:0] ST_SHIFT    = 3'd2;
	localparam logic [2:0] ST_LP_WAIT  = 3'd3;
	localparam logic [2:0] ST_LP_HOLD  = 3'd4;
	localparam logic [2:0] ST_LP_END   = 3'd5;
	localparam logic [2:0] ST_LINE_GAP = 3'd6;

	localparam int LP_CNT_W = ($clog2(`LCM_LP_DELAY) > 0) ? $clog2(`LCM_LP_DELAY) : 1;

	logic [2:0]          state;
	logic [LP_CNT_W-1:0] lp_cnt;
	logic                clk_en;   // gates xscl
	logic                xscl_q;
	logic                rise_evt;
	logic                fall_evt;
	logic                line_end;
	logic                first_line;
	logic                more_bytes;

	assign rise_evt = lcm_clk_event & lcm_clk;
	assign fall_evt = lcm_clk_event & ~lcm_clk;

	// decided one byte early, the index is advanced on the same event
	assign line_end   = ((int'(rd_index) + 2) % LCM_WIDTH_BYTES) == 0;
	assign first_line = (int'(rd_index) + 2) == LCM_WIDTH_BYTES;
	assign more_bytes = int'(rd_index) < (LCM_DATA_BYTES - 1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			lp_cnt   <= '0;
			clk_en   <= 1'b0;
			rd_index <= '0;
			lcm_lp   <= 1'b0;
			lcm_din  <= 1'b0;
		end else begin
			lcm_lp <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (request_update) begin
						state <= ST_START;
					end
				end
				ST_START: begin
					if (rise_evt) begin  // first byte on a rising panel clock
						clk_en   <= 1'b1;
						rd_index <= '0;
						state    <= ST_SHIFT;
					end
				end
				ST_SHIFT: begin
					if (rise_evt) begin
						if (line_end) begin
							if (first_line) begin
								lcm_din <= 1'b1;  // frame start flag
							end
							state <= ST_LP_WAIT;
						end
						if (more_bytes) begin
							clk_en   <= 1'b1;
							rd_index <= rd_index + 1'b1;
						end else begin
							clk_en   <= 1'b0;  // frame done
							rd_index <= '0;
							state    <= ST_IDLE;
						end
					end
				end
				ST_LP_WAIT: begin
					if (fall_evt) begin  // last byte sampled on this edge
						clk_en <= 1'b0;
						lcm_lp <= 1'b1;
						lp_cnt <= '0;
						state  <= ST_LP_HOLD;
					end
				end
				ST_LP_HOLD: begin
					lcm_lp <= 1'b1;
					if (rise_evt) begin
						if (lp_cnt == LP_CNT_W'(`LCM_LP_DELAY - 1)) begin
							lp_cnt <= '0;
							state  <= ST_LP_END;
						end else begin
							lp_cnt <= lp_cnt + 1'b1;
						end
					end
				end
				ST_LP_END: begin
					if (fall_evt) begin  // lp already low here
						state <= ST_LINE_GAP;
					end
				end
				ST_LINE_GAP: begin
					if (rise_evt) begin
						lcm_din <= 1'b0;
						state   <= ST_SHIFT;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// xscl trails lcm_clk by one clk cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			xscl_q <= 1'b0;
		end else if (lcm_clk_event) begin
			xscl_q <= lcm_clk;
		end
	end

	assign xscl = clk_en & xscl_q;
	assign busy = (state != ST_IDLE);

endmodule

`default_nettype wire

// ==== lcm_display_top.f ====
+incdir+hdl
hdl/lcm_pkg.sv
hdl/lcm_clk_gen.sv
hdl/lcm_timing_ctrl.sv
hdl/lcm_frame_buf.sv
hdl/lcm_host_if.sv
hdl/lcm_display_top.sv
testbench/lcm_display_chk.sv
testbench/lcm_display_tb.sv

// ==== testbench/lcm_display_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcm_display_chk (
	input wire                 clk,
	input wire                 rst_n,
	input wire                 lcm_clk_event,
	input wire                 xscl,
	input wire                 lcm_lp,
	input wire                 busy,
	input lcm_pkg::lcm_index_t rd_index
);

	// shift clock is gated off for the whole latch pulse
	xscl_quiet_in_lp: assert property (@(posedge clk) disable iff (!rst_n)
		lcm_lp |-> !xscl)
		else $error("xscl high while lp is high");

	lp_low_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> !lcm_lp)
		else $error("lp high while the timing controller is idle");

	// index moves only on a panel clock event and gives lcm_data time to settle
	index_on_event: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_index != $past(rd_index)) |-> $past(lcm_clk_event))
		else $error("read index moved without a panel clock event");

endmodule

bind lcm_timing_ctrl lcm_display_chk chk_i (
	.clk           (clk),
	.rst_n         (rst_n),
	.lcm_clk_event (lcm_clk_event),
	.xscl          (xscl),
	.lcm_lp        (lcm_lp),
	.busy          (busy),
	.rd_index      (rd_index)
);

`default_nettype wire

// ==== testbench/lcm_display_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lcm_settings.svh"

module lcm_display_tb;

	import lcm_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int FRAMES       = 3;
	localparam int HALF_CYCLES  = `LCM_CLK_DIV;
	localparam int LP_CYCLES    = `LCM_LP_DELAY * 2 * HALF_CYCLES;
	localparam int FRAME_CYCLES = (LCM_DATA_BYTES + `LCM_HEIGHT_LINES * (`LCM_LP_DELAY + 4))
		* 2 * HALF_CYCLES;
	localparam int MARGIN       = 2000;  // writes, reset and idle gaps, in clk cycles

	logic      clk;
	logic      rst_n;
	logic      req;
	lcm_cmd_u  cmd;
	logic      ack;
	logic      xscl;
	logic      lcm_lp;
	logic      lcm_din;
	logic      busy;
	lcm_byte_t lcm_data;

	lcm_byte_t   ref_mem   [LCM_DATA_BYTES];  // mirror of every host write
	lcm_byte_t   exp_frame [LCM_DATA_BYTES];  // contents at refresh ack
	logic [31:0] rng_state;
	logic        refresh_seen;
	logic        xscl_prev;
	logic        lp_prev;
	logic        busy_prev;
	int          cycle;
	int          byte_cnt;
	int          line_bytes;
	int          lp_cnt;
	int          lp_start;
	int          frames_done;

	lcm_display_top dut_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (req),
		.cmd      (cmd),
		.ack      (ack),
		.xscl     (xscl),
		.lcm_lp   (lcm_lp),
		.lcm_din  (lcm_din),
		.busy     (busy),
		.lcm_data (lcm_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// panel shifts the frame out in index order, byte n at the n-th xscl fall
	function automatic lcm_byte_t expected_byte(input int pos);
		return exp_frame[pos];
	endfunction

	task automatic fail_run(input string why);
		$display("run stopped at %0t ns because %s", $time, why);
		$display("ERRORS FOUND");
		$fatal(1, "run aborted");
	endtask

	task automatic chk_byte(input lcm_byte_t got, input lcm_byte_t want, input string what);
		if (got !== want) begin
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, want);
			$display("ERRORS FOUND");
			$fatal(1, "byte mismatch");
		end
	endtask

	task automatic chk_count(input lcm_index_t got, input lcm_index_t want, input string what);
		if (got !== want) begin
			$display("ERR %0t ns: %s is %0d, expected %0d", $time, what, got, want);
			$display("ERRORS FOUND");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic chk_flag(input logic got, input logic want, input string what);
		if (got !== want) begin
			$display("ERR %0t ns: %s is %b, expected %b", $time, what, got, want);
			$display("ERRORS FOUND");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic start_req(input lcm_cmd_u c);
		@(negedge clk);
		cmd = c;
		req = 1'b1;
	endtask

	task automatic wait_ack(input logic level);
		while (ack !== level) @(negedge clk);
	endtask

	task automatic send_cmd(input lcm_cmd_u c);
		start_req(c);
		wait_ack(1'b1);
		req = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic write_pixel(input lcm_index_t addr, input lcm_byte_t data);
		lcm_cmd_u c;
		c          = '0;
		c.pix.op   = op_write_pixel;
		c.pix.addr = addr;
		c.pix.data = data;
		ref_mem[addr] = data;
		send_cmd(c);
	endtask

	task automatic send_refresh(input logic while_busy);
		lcm_cmd_u c;
		c               = '0;
		c.ctl.op        = op_refresh;
		c.ctl.full_frame = 1'b1;
		refresh_seen    = 1'b1;
		start_req(c);
		if (while_busy) begin
			chk_flag(busy, 1'b1, "busy when refresh is requested mid-frame");
		end
		wait_ack(1'b1);
		chk_flag(busy, 1'b0, "busy at refresh ack");  // acked only once idle
		exp_frame = ref_mem;
		req = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic wait_frames(input int n);
		while (frames_done < n) @(negedge clk);
	endtask

	// panel model, sampled half a clk after every output edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (!refresh_seen) begin
				chk_flag(xscl, 1'b0, "xscl before first refresh");
				chk_flag(lcm_lp, 1'b0, "lp before first refresh");
				chk_flag(lcm_din, 1'b0, "din before first refresh");
				chk_flag(busy, 1'b0, "busy before first refresh");
			end
			if (xscl_prev && !xscl) begin
				if (byte_cnt >= LCM_DATA_BYTES) begin
					fail_run("the panel was clocked more bytes than one frame holds");
				end
				chk_byte(lcm_data, expected_byte(byte_cnt), "panel data byte");
				byte_cnt++;
				line_bytes++;
			end
			if (!lp_prev && lcm_lp) begin
				chk_count(lcm_index_t'(line_bytes), lcm_index_t'(LCM_WIDTH_BYTES),
					"bytes before latch");
				chk_flag(lcm_din, lp_cnt == 0, "din at latch start");  // first line only
				line_bytes = 0;
				lp_start   = cycle;
			end
			if (lp_prev && !lcm_lp) begin
				chk_flag(lcm_din, lp_cnt == 0, "din at latch end");
				chk_flag((cycle - lp_start > LP_CYCLES - 2 * HALF_CYCLES)
					&& (cycle - lp_start < LP_CYCLES + 2 * HALF_CYCLES), 1'b1,
					"lp width within one panel clock");
				lp_cnt++;
			end
			if (busy_prev && !busy) begin  // frame end
				chk_count(lcm_index_t'(lp_cnt), lcm_index_t'(`LCM_HEIGHT_LINES), "latch pulses");
				chk_count(lcm_index_t'(line_bytes), '0, "bytes after last latch");
				byte_cnt   = 0;
				line_bytes = 0;
				lp_cnt     = 0;
				frames_done++;
			end
		end
		xscl_prev = xscl;
		lp_prev   = lcm_lp;
		busy_prev = busy;
		cycle++;
	end

	initial begin
		#((FRAMES * FRAME_CYCLES + MARGIN) * CLK_PERIOD);
		$display("timeout, the run did not finish in the expected time");
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

	initial begin
		lcm_cmd_u nop_cmd;
		rst_n        = 1'b0;
		req          = 1'b0;
		cmd          = '0;
		rng_state    = 32'h52541555;
		refresh_seen = 1'b0;
		xscl_prev    = 1'b0;
		lp_prev      = 1'b0;
		busy_prev    = 1'b0;
		cycle        = 0;
		byte_cnt     = 0;
		line_bytes   = 0;
		lp_cnt       = 0;
		lp_start     = 0;
		frames_done  = 0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		repeat (16) begin
			@(negedge clk);
			chk_flag(ack, 1'b0, "ack after reset");
		end

		for (int i = 0; i < LCM_DATA_BYTES; i++) begin
			rng_state = xorshift32(rng_state);
			write_pixel(lcm_index_t'(i), rng_state[7:0]);
		end
		send_refresh(1'b0);

		// write behind the scan, must show up only in the next frame
		while (byte_cnt < 2 * LCM_WIDTH_BYTES) @(negedge clk);
		rng_state = xorshift32(rng_state);
		write_pixel('0, rng_state[7:0]);
		chk_flag(busy, 1'b1, "busy after mid-frame write");
		send_refresh(1'b1);
		chk_count(lcm_index_t'(frames_done), lcm_index_t'(1), "frames before second refresh");
		wait_frames(2);

		nop_cmd          = '0;
		nop_cmd.pix.op   = op_nop;
		nop_cmd.pix.addr = '0;
		nop_cmd.pix.data = ~ref_mem[0];  // caught by the next frame if written
		send_cmd(nop_cmd);
		repeat (4 * 2 * HALF_CYCLES) begin
			@(negedge clk);
			chk_flag(busy, 1'b0, "busy after nop");
		end
		send_refresh(1'b0);
		wait_frames(3);

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire
